/* logic/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// data and PC width
`define DEC_XLEN     32
// register file index width
`define DEC_REG_IDX  5

// instruction field positions
`define DEC_OPC_HI   6
`define DEC_OPC_LO   0
`define DEC_RD_HI    11
`define DEC_RD_LO    7
`define DEC_F3_HI    14
`define DEC_F3_LO    12
`define DEC_RS1_HI   19
`define DEC_RS1_LO   15
`define DEC_RS2_HI   24
`define DEC_RS2_LO   20

// selects SUB and SRA
`define DEC_ALT_BIT  30

`endif

/* logic/decodePkg.sv */
`include "decode_config.svh"

package decodePkg;

    typedef logic [`DEC_XLEN-1:0]    word_t;
    typedef logic [`DEC_XLEN-1:0]    addr_t;
    typedef logic [`DEC_REG_IDX-1:0] regIdx_t;
    typedef logic [2:0]              funct3_t;
    typedef logic [6:0]              opcode_t;

    typedef enum logic [1:0] {
        idle,
        empty,
        full
    } stageState_t;

    typedef struct packed {
        word_t instr;
        addr_t curPc;
        addr_t nxtPc;
    } fetch_t;

    // valid high means val is an immediate, else idx names a register
    typedef struct packed {
        logic    valid;
        regIdx_t idx;
        word_t   val;
    } operand_t;

    typedef struct packed {
        word_t immI;
        word_t immS;
        word_t immB;
        word_t immU;
        word_t immJ;
    } imm_t;

    typedef struct packed {
        // unit selects
        logic       lsUse;
        logic       aluUse;
        logic       jmpUse;
        logic       ldPcUse;
        operand_t   src1;
        operand_t   src2;
        operand_t   src3;
        regIdx_t    rdIdx;
        // load/store
        logic       isMemLoad;
        logic [1:0] ldSize;
        logic       ldExtendMode;
        // alu
        logic       isAdd;
        logic       isSub;
        logic       isXor;
        logic       isOr;
        logic       isAnd;
        logic       isSlt;
        logic       isSltu;
        logic       isSll;
        logic       isSrl;
        logic       isSra;
        // jump/branch
        logic       isJalR;
        logic       isJal;
        logic       jumpExtendMode;
        logic       isEq;
        logic       isNEq;
        logic       isLt;
        logic       isGe;
        logic       isNeedPc;
        addr_t      pc;
        addr_t      nextPc;
    } uop_t;

endpackage

/* logic/stageControl.sv */
`timescale 1ns/100ps

module stageControl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic inVld,
    input  logic outRdy,
    output logic inRdy,
    output logic outVld,
    output logic load
);
    import decodePkg::*;

    stageState_t state;

    // a full stage frees its slot in the same cycle it drains
    assign inRdy  = (state == empty) || ((state == full) && outRdy);
    assign outVld = (state == full);
    assign load   = inVld && inRdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= empty;
                    end
                end
                empty: begin
                    if (load) begin
                        state <= full;
                    end
                end
                full: begin
                    // load while draining keeps it full
                    if (!load && outRdy) begin
                        state <= empty;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* logic/immGen.sv */
`timescale 1ns/100ps

module immGen (
    input  decodePkg::word_t instr,
    output decodePkg::imm_t  imm
);

    logic sign;

    assign sign = instr[31];

    // loads, OP-IMM and JALR
    assign imm.immI = {{20{sign}}, instr[31:20]};

    // stores
    assign imm.immS = {{20{sign}}, instr[31:25], instr[11:7]};

    // branch offsets are halfword aligned
    assign imm.immB = {
        {19{sign}},
        sign,
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // LUI and AUIPC
    assign imm.immU = {instr[31:12], 12'b0};

    // JAL offset, sign-extended
    assign imm.immJ = {
        {11{sign}},
        sign,
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

endmodule

/* logic/uopDecode.sv */
`timescale 1ns/100ps
`include "decode_config.svh"

module uopDecode (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  decodePkg::fetch_t fetch,
    input  decodePkg::imm_t   imm,
    output decodePkg::uop_t   uop
);
    import decodePkg::*;

    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opImm    = 7'b0010011;
    localparam opcode_t opReg    = 7'b0110011;
    localparam opcode_t opLui    = 7'b0110111;
    localparam opcode_t opAuipc  = 7'b0010111;
    localparam opcode_t opBranch = 7'b1100011;
    localparam opcode_t opJalr   = 7'b1100111;
    localparam opcode_t opJal    = 7'b1101111;

    opcode_t opc;
    funct3_t f3;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    logic    alt;
    logic    isOpReg;
    uop_t    nxt;

    function automatic operand_t regOp(input regIdx_t idx);
        operand_t o;
        o = '0;
        o.idx = idx;
        return o;
    endfunction

    function automatic operand_t immOp(input word_t val);
        operand_t o;
        o = '0;
        o.valid = 1'b1;
        o.val = val;
        return o;
    endfunction

    assign opc     = fetch.instr[`DEC_OPC_HI:`DEC_OPC_LO];
    assign f3      = fetch.instr[`DEC_F3_HI:`DEC_F3_LO];
    assign rs1     = fetch.instr[`DEC_RS1_HI:`DEC_RS1_LO];
    assign rs2     = fetch.instr[`DEC_RS2_HI:`DEC_RS2_LO];
    assign rd      = fetch.instr[`DEC_RD_HI:`DEC_RD_LO];
    assign alt     = fetch.instr[`DEC_ALT_BIT];
    assign isOpReg = (opc == opReg);

    // unknown opcodes fall through with every unit select low
    always_comb begin
        nxt = '0;
        nxt.pc = fetch.curPc;
        nxt.nextPc = fetch.nxtPc;
        case (opc)
            opLoad, opStore: begin
                nxt.lsUse = 1'b1;
                nxt.src1 = regOp(rs1);
                nxt.isMemLoad = (opc == opLoad);
                nxt.ldSize = f3[1:0];
                nxt.ldExtendMode = f3[2];
                if (opc == opLoad) begin
                    nxt.src3 = immOp(imm.immI);
                    nxt.rdIdx = rd;
                end else begin
                    nxt.src2 = regOp(rs2);
                    nxt.src3 = immOp(imm.immS);
                end
            end
            opImm, opReg: begin
                nxt.aluUse = 1'b1;
                nxt.src1 = regOp(rs1);
                nxt.src2 = isOpReg ? regOp(rs2) : immOp(imm.immI);
                nxt.rdIdx = rd;
                nxt.isSub = (f3 == 3'b000) && isOpReg && alt;
                nxt.isAdd = (f3 == 3'b000) && !(isOpReg && alt);
                nxt.isXor = (f3 == 3'b100);
                nxt.isOr = (f3 == 3'b110);
                nxt.isAnd = (f3 == 3'b111);
                nxt.isSlt = (f3 == 3'b010);
                nxt.isSltu = (f3 == 3'b011);
                nxt.isSll = (f3 == 3'b001);
                nxt.isSrl = (f3 == 3'b101) && !alt;
                nxt.isSra = (f3 == 3'b101) && alt;
            end
            opLui, opAuipc: begin
                nxt.ldPcUse = 1'b1;
                nxt.src2 = immOp(imm.immU);
                nxt.rdIdx = rd;
                nxt.isNeedPc = (opc == opAuipc);
            end
            opBranch: begin
                nxt.jmpUse = 1'b1;
                nxt.src1 = regOp(rs1);
                nxt.src2 = regOp(rs2);
                nxt.src3 = immOp(imm.immB);
                // unsigned compare for bltu/bgeu
                nxt.jumpExtendMode = f3[1];
                nxt.isEq = (f3 == 3'b000);
                nxt.isNEq = (f3 == 3'b001);
                nxt.isLt = (f3 == 3'b100) || (f3 == 3'b110);
                nxt.isGe = (f3 == 3'b101) || (f3 == 3'b111);
            end
            opJalr: begin
                nxt.jmpUse = 1'b1;
                nxt.isJalR = 1'b1;
                nxt.src1 = regOp(rs1);
                nxt.src2 = immOp(imm.immI);
                nxt.rdIdx = rd;
            end
            opJal: begin
                nxt.jmpUse = 1'b1;
                nxt.isJal = 1'b1;
                nxt.src1 = immOp('0);
                nxt.src2 = immOp(imm.immJ);
                nxt.rdIdx = rd;
            end
            default: begin
                nxt.lsUse = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uop <= '0;
        end else if (load) begin
            uop <= nxt;
        end
    end

endmodule

/* logic/decodeTop.sv */
`timescale 1ns/100ps

module decodeTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              inVld,
    input  decodePkg::fetch_t fetch,
    input  logic              outRdy,
    output logic              inRdy,
    output logic              outVld,
    output decodePkg::uop_t   uop
);
    import decodePkg::*;

    logic load;
    imm_t imm;

    stageControl ctrl (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .inVld  (inVld),
        .outRdy (outRdy),
        .inRdy  (inRdy),
        .outVld (outVld),
        .load   (load)
    );

    immGen immUnit (
        .instr (fetch.instr),
        .imm   (imm)
    );

    // decode and output register
    uopDecode dec (
        .clk   (clk),
        .rst   (rst),
        .load  (load),
        .fetch (fetch),
        .imm   (imm),
        .uop   (uop)
    );

endmodule

/* bench/decode_asserts.sv */
`timescale 1ns/100ps

module decodeAsserts (
    input logic             clk,
    input logic             rst,
    input logic             start,
    input logic             inVld,
    input logic             inRdy,
    input logic             outVld,
    input logic             outRdy,
    input decodePkg::uop_t  uop
);

    logic started;
    logic accepted;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            accepted <= 1'b0;
        end else begin
            started <= started | start;
            accepted <= accepted | (inVld & inRdy);
        end
    end

    idleNotReady: assert property (@(posedge clk) disable iff (rst)
        !started |-> !inRdy) else $error("inRdy high while the stage is idle");

    noEarlyValid: assert property (@(posedge clk) disable iff (rst)
        !accepted |-> !outVld) else $error("outVld high before any fetch was accepted");

    holdUnderStall: assert property (@(posedge clk) disable iff (rst)
        outVld && !outRdy |=> outVld && $stable(uop)) else $error("uop changed while stalled");

    // at most one execution unit per micro-op
    oneUnit: assert property (@(posedge clk) disable iff (rst)
        outVld |-> $countones({uop.lsUse, uop.aluUse, uop.jmpUse, uop.ldPcUse}) <= 1)
        else $error("more than one unit select set");

endmodule

bind decodeTop decodeAsserts checks (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .inVld  (inVld),
    .inRdy  (inRdy),
    .outVld (outVld),
    .outRdy (outRdy),
    .uop    (uop)
);

/* bench/decodeTb.sv */
`timescale 1ns/100ps

module decodeTb;
    import decodePkg::*;

    // the tests need about 1000 cycles
    localparam int maxCycles = 4000;

    logic   clk;
    logic   rst;
    logic   start;
    logic   inVld;
    logic   outRdy;
    logic   inRdy;
    logic   outVld;
    fetch_t fetch;
    uop_t   uop;

    uop_t        expQ[$];
    logic [31:0] rngState;
    addr_t       pcNext;
    string       testName;
    int          cycles;

    decodeTop DUT (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .inVld  (inVld),
        .fetch  (fetch),
        .outRdy (outRdy),
        .inRdy  (inRdy),
        .outVld (outVld),
        .uop    (uop)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic fetch_t fetchFor(input word_t instr);
        fetch_t f;
        f.instr = instr;
        f.curPc = pcNext;
        f.nxtPc = pcNext + 32'd4;
        pcNext = pcNext + 32'd4;
        return f;
    endfunction

    // expected micro-op from the RV32I encodings
    function automatic uop_t refUop(input fetch_t f);
        uop_t        u;
        logic [31:0] i;
        logic [2:0]  f3;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        i = f.instr;
        f3 = i[14:12];
        immI = $signed(i) >>> 20;
        immS = {immI[31:5], i[11:7]};
        immB = {immI[31:12], i[7], i[30:25], i[11:8], 1'b0};
        immU = i & 32'hffff_f000;
        immJ = {immI[31:20], i[19:12], i[20], i[30:21], 1'b0};
        u = '0;
        u.pc = f.curPc;
        u.nextPc = f.nxtPc;
        case (i[6:0])
            7'h03, 7'h23: begin
                u.lsUse = 1'b1;
                u.src1 = '{1'b0, i[19:15], 32'h0};
                u.isMemLoad = ~i[5];
                u.ldSize = f3[1:0];
                u.ldExtendMode = i[14];
                if (i[5]) begin
                    u.src2 = '{1'b0, i[24:20], 32'h0};
                    u.src3 = '{1'b1, 5'd0, immS};
                end else begin
                    u.src3 = '{1'b1, 5'd0, immI};
                    u.rdIdx = i[11:7];
                end
            end
            7'h13, 7'h33: begin
                u.aluUse = 1'b1;
                u.src1 = '{1'b0, i[19:15], 32'h0};
                if (i[5]) begin
                    u.src2 = '{1'b0, i[24:20], 32'h0};
                end else begin
                    u.src2 = '{1'b1, 5'd0, immI};
                end
                u.rdIdx = i[11:7];
                case (f3)
                    3'b000: begin
                        // sub only exists in OP
                        u.isSub = i[5] & i[30];
                        u.isAdd = ~(i[5] & i[30]);
                    end
                    3'b100: u.isXor = 1'b1;
                    3'b110: u.isOr = 1'b1;
                    3'b111: u.isAnd = 1'b1;
                    3'b010: u.isSlt = 1'b1;
                    3'b011: u.isSltu = 1'b1;
                    3'b001: u.isSll = 1'b1;
                    default: begin
                        u.isSra = i[30];
                        u.isSrl = ~i[30];
                    end
                endcase
            end
            7'h37, 7'h17: begin
                u.ldPcUse = 1'b1;
                u.src2 = '{1'b1, 5'd0, immU};
                u.rdIdx = i[11:7];
                u.isNeedPc = ~i[5];
            end
            7'h63: begin
                u.jmpUse = 1'b1;
                u.src1 = '{1'b0, i[19:15], 32'h0};
                u.src2 = '{1'b0, i[24:20], 32'h0};
                u.src3 = '{1'b1, 5'd0, immB};
                u.jumpExtendMode = f3[1];
                u.isEq = (f3 == 3'b000);
                u.isNEq = (f3 == 3'b001);
                u.isLt = f3[2] & ~f3[0];
                u.isGe = f3[2] & f3[0];
            end
            7'h67: begin
                u.jmpUse = 1'b1;
                u.isJalR = 1'b1;
                u.src1 = '{1'b0, i[19:15], 32'h0};
                u.src2 = '{1'b1, 5'd0, immI};
                u.rdIdx = i[11:7];
            end
            7'h6f: begin
                u.jmpUse = 1'b1;
                u.isJal = 1'b1;
                u.src1 = '{1'b1, 5'd0, 32'h0};
                u.src2 = '{1'b1, 5'd0, immJ};
                u.rdIdx = i[11:7];
            end
            default: begin
                u.lsUse = 1'b0;
            end
        endcase
        return u;
    endfunction

    // nine supported classes plus fence, system and an all-zero opcode
    function automatic word_t randInstr();
        opcode_t     opcList[12];
        logic [31:0] r;
        opcList = '{7'h03, 7'h23, 7'h13, 7'h33, 7'h37, 7'h17,
                    7'h63, 7'h6f, 7'h67, 7'h0f, 7'h73, 7'h00};
        r = nextRand();
        return {r[31:7], opcList[nextRand() % 12]};
    endfunction

    task automatic checkValue(input string name, input logic [255:0] expected,
                              input logic [255:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // every transferred micro-op is compared in order
    always @(posedge clk) begin
        if (!rst && outVld && outRdy) begin
            if (expQ.size() == 0) begin
                $display("A micro-op came out in %s with no instruction pending", testName);
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected output");
            end else begin
                checkValue(testName, expQ.pop_front(), uop);
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= maxCycles) begin
                $display("Timeout: the run did not finish within %0d cycles", maxCycles);
                $display("SIMULATION FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic sendFetch(input fetch_t f);
        fetch <= f;
        inVld <= 1'b1;
        @(posedge clk);
        while (!inRdy) @(posedge clk);
        expQ.push_back(refUop(f));
        inVld <= 1'b0;
    endtask

    task automatic sendAndExpect(input word_t instr);
        sendFetch(fetchFor(instr));
        @(posedge clk);
        checkValue({testName, " latency"}, 1'b1, outVld);
    endtask

    // the stage holds one item, so a few cycles always suffice
    task automatic drain();
        int waited;
        inVld <= 1'b0;
        outRdy <= 1'b1;
        waited = 0;
        while ((expQ.size() != 0) && (waited < 8)) begin
            @(posedge clk);
            waited++;
        end
        @(posedge clk);
    endtask

    task automatic idleTest();
        testName = "idleTest";
        fetch <= fetchFor(32'h0000_0013);
        inVld <= 1'b1;
        outRdy <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            checkValue("idleTest inRdy/outVld", 2'b00, {inRdy, outVld});
        end
        inVld <= 1'b0;
    endtask

    task automatic classTest();
        word_t classList[9];
        testName = "classTest";
        classList = '{{7'h7f, 5'h1c, 5'd10, 3'b010, 5'd5, 7'h03},
                      {7'h40, 5'd7, 5'd2, 3'b001, 5'd9, 7'h23},
                      {7'h01, 5'd3, 5'd4, 3'b000, 5'd6, 7'h13},
                      {7'h20, 5'd8, 5'd9, 3'b000, 5'd1, 7'h33},
                      {7'h55, 5'd21, 5'd13, 3'b101, 5'd31, 7'h37},
                      {7'h2a, 5'd10, 5'd2, 3'b011, 5'd3, 7'h17},
                      {7'h7e, 5'd5, 5'd6, 3'b100, 5'd11, 7'h63},
                      {7'h49, 5'd17, 5'd30, 3'b110, 5'd1, 7'h6f},
                      {7'h00, 5'd12, 5'd1, 3'b000, 5'd0, 7'h67}};
        outRdy <= 1'b1;
        foreach (classList[k]) begin
            sendAndExpect(classList[k]);
        end
        drain();
    endtask

    task automatic functTest();
        logic [31:0] r;
        testName = "functTest";
        outRdy <= 1'b1;
        for (int fn = 0; fn < 8; fn++) begin
            for (int alt = 0; alt < 2; alt++) begin
                r = nextRand();
                sendAndExpect({1'b0, alt[0], r[29:15], fn[2:0], r[11:7], 7'h13});
                sendAndExpect({1'b0, alt[0], r[29:15], fn[2:0], r[11:7], 7'h33});
            end
            r = nextRand();
            sendAndExpect({r[31:15], fn[2:0], r[11:7], 7'h63});
        end
        drain();
    endtask

    task automatic backPressureTest();
        fetch_t held;
        testName = "backPressure";
        outRdy <= 1'b0;
        sendFetch(fetchFor(32'h00c0_0293));
        held = fetchFor({7'h20, 5'd3, 5'd2, 3'b101, 5'd4, 7'h33});
        // offered while full and must not be taken
        fetch <= held;
        inVld <= 1'b1;
        repeat (6) begin
            @(posedge clk);
            checkValue("backPressure outVld", 1'b1, outVld);
            checkValue("backPressure inRdy", 1'b0, inRdy);
            checkValue("backPressure uop", expQ[0], uop);
        end
        outRdy <= 1'b1;
        sendFetch(held);
        sendFetch(fetchFor({7'h7f, 5'h1f, 5'd8, 3'b100, 5'd2, 7'h03}));
        sendFetch(fetchFor({7'h7f, 5'h1e, 5'd31, 3'b111, 5'd0, 7'h6f}));
        drain();
    endtask

    task automatic randomStream();
        logic [31:0] r;
        int          offered;
        int          sent;
        testName = "randomStream";
        offered = 0;
        sent = 0;
        while (sent < 300) begin
            @(posedge clk);
            if (inVld && inRdy) begin
                expQ.push_back(refUop(fetch));
                sent++;
            end
            r = nextRand();
            outRdy <= (r[1:0] != 2'b00);
            // a new offer only once the previous one was taken
            if (!inVld || inRdy) begin
                if ((r[3:2] != 2'b00) && (offered < 300)) begin
                    fetch <= fetchFor(randInstr());
                    inVld <= 1'b1;
                    offered++;
                end else begin
                    inVld <= 1'b0;
                end
            end
        end
        drain();
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        inVld = 1'b0;
        outRdy = 1'b0;
        fetch = '0;
        rngState = 32'hc5c0fc13;
        pcNext = 32'h0000_1000;
        testName = "reset";
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        idleTest();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        classTest();
        functTest();
        backPressureTest();
        randomStream();
        if (expQ.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d instructions never came out of the stage", expQ.size());
            $display("SIMULATION FAILED");
            $fatal(1, "instructions lost");
        end
    end

endmodule

/* list.f */
+incdir+logic
logic/decodePkg.sv
logic/stageControl.sv
logic/immGen.sv
logic/uopDecode.sv
logic/decodeTop.sv
bench/decode_asserts.sv
bench/decodeTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/decodePkg.sv
      - logic/stageControl.sv
      - logic/immGen.sv
      - logic/uopDecode.sv
      - logic/decodeTop.sv
  - target: simulation
    files:
      - bench/decode_asserts.sv
      - bench/decodeTb.sv
